// ==== common/opn_cfg.svh ====
//------------------------------
// build options for the OPN timing block
// include in any file that reads one of the macros
//------------------------------
`ifndef OPN_CFG_SVH
`define OPN_CFG_SVH

// channel count of the part, 6 or 3
// 6 locks the divider at /6 and kills the ssg strobe
`define OPN_NUM_CH 3

// square wave generator present
`define OPN_USE_SSG 1

// opn strobes of busy after each host write
`define OPN_BUSY_TICKS 4

// interval timer widths
`define OPN_TA_W 10
`define OPN_TB_W 8

// timer b counts once per this many opn strobes
`define OPN_TB_SUB 16

`endif

// ==== common/opn_reg_pkg.sv ====
//------------------------------
// host side register map and bus types
// import where register fields are decoded
//------------------------------
package opn_reg_pkg;

    // one 8-bit register per address
    typedef enum logic [7:0] {
        REG_TA_HI     = 8'h24,  // timer a bits 9..2
        REG_TA_LO     = 8'h25,  // timer a bits 1..0
        REG_TB        = 8'h26,
        REG_TIMER_CTL = 8'h27,
        REG_PRESCALE  = 8'h2D   // data 1..0 picks the divider
    } reg_addr_e;

    // layout of the timer control register, bit 0 at the bottom
    typedef struct packed {
        logic [1:0] spare;      // ch3 mode on the real part
        logic       rst_b;
        logic       rst_a;
        logic       flag_en_b;
        logic       flag_en_a;
        logic       load_b;
        logic       load_a;     // bit 0
    } timer_ctl_t;

    // one host write beat
    typedef struct packed {
        reg_addr_e  addr;
        logic [7:0] data;
    } host_wr_t;

endpackage

// ==== common/opn_timing_pkg.sv ====
//------------------------------
// divider setting and strobe bundle
// import where strobes are made or consumed
//------------------------------
package opn_timing_pkg;

    // prescaler register value
    // 2'b01 also selects /2 and decodes through the default arm
    typedef enum logic [1:0] {
        DIV_2 = 2'b00,  // opn /2, ssg /1
        DIV_6 = 2'b10,  // opn /6, ssg /4
        DIV_3 = 2'b11   // opn /3, ssg /2
    } div_sel_e;

    // single cycle clock enables for the sound engines
    typedef struct packed {
        logic opn;      // operator rate
        logic ssg;      // square wave generator
        logic adpcm;    // every 4th opn strobe
    } strobe_t;

endpackage

// ==== verilog/opn_clk_div.sv ====
//------------------------------
// cen divider for opn, ssg and adpcm strobes
// ratio follows div_sel unless the part is 6 channel
//------------------------------
`include "opn_cfg.svh"

module opn_clk_div (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     cen,
    input  opn_timing_pkg::div_sel_e div_sel,
    output opn_timing_pkg::strobe_t  stb
);
    import opn_timing_pkg::*;

    localparam logic SSG_ON = (`OPN_USE_SSG != 0) && (`OPN_NUM_CH != 6);

    logic [2:0] opn_max;    // period minus one
    logic [1:0] ssg_max;
    logic [2:0] opn_cnt;
    logic [1:0] ssg_cnt;
    logic [1:0] adpcm_cnt;  // counts opn wraps
    logic       opn_zero;
    logic       ssg_zero;

    // period lookup
    always_comb begin
        if (`OPN_NUM_CH == 6) begin
            opn_max = 3'd5;     // six channel parts always /6
            ssg_max = 2'd3;
        end else begin
            case (div_sel)
                DIV_6: begin
                    opn_max = 3'd5;
                    ssg_max = 2'd3;
                end
                DIV_3: begin
                    opn_max = 3'd2;
                    ssg_max = 2'd1;
                end
                default: begin  // 00 and 01
                    opn_max = 3'd1;
                    ssg_max = 2'd0;
                end
            endcase
        end
    end

    assign opn_zero = (opn_cnt == 3'd0);
    assign ssg_zero = (ssg_cnt == 2'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opn_cnt   <= '0;
            ssg_cnt   <= '0;
            adpcm_cnt <= '0;
        end else if (cen) begin
            // >= so a smaller ratio written mid-count still wraps
            opn_cnt <= (opn_cnt >= opn_max) ? 3'd0 : opn_cnt + 3'd1;
            ssg_cnt <= (ssg_cnt >= ssg_max) ? 2'd0 : ssg_cnt + 2'd1;
            if (opn_zero) begin
                adpcm_cnt <= adpcm_cnt + 2'd1;
            end
        end
    end

    // strobes land one cycle after the enabling cen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stb <= '0;
        end else begin
            stb.opn   <= cen & opn_zero;
            stb.ssg   <= SSG_ON & cen & ssg_zero;
            stb.adpcm <= cen & opn_zero & (adpcm_cnt == 2'd0);
        end
    end

    // spacing monitor for the strobe check
    logic [2:0] since_opn;  // cycles since last opn strobe, saturates
    logic       sel_moved;  // ratio changed inside the window
    div_sel_e   div_sel_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_opn <= '1;
            sel_moved <= 1'b1;
            div_sel_q <= DIV_6;
        end else begin
            div_sel_q <= div_sel;
            if (stb.opn) begin
                since_opn <= 3'd1;
                sel_moved <= (div_sel != div_sel_q);
            end else begin
                if (since_opn != '1) begin
                    since_opn <= since_opn + 3'd1;
                end
                if (div_sel != div_sel_q) begin
                    sel_moved <= 1'b1;
                end
            end
        end
    end

    // no two opn strobes closer than one period
    a_opn_spacing: assert property (@(posedge clk) disable iff (!arst_n)
        stb.opn && !sel_moved && (div_sel == div_sel_q) |-> since_opn > opn_max);

    a_adpcm_in_opn: assert property (@(posedge clk) disable iff (!arst_n)
        stb.adpcm |-> stb.opn);

endmodule

// ==== timers/opn_timer.sv ====
//------------------------------
// loadable up-counting interval timer
// SUB above 1 adds a tick prescaler in front
//------------------------------
module opn_timer #(
    parameter int WIDTH = 10,
    parameter int SUB   = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             tick,
    input  logic [WIDTH-1:0] value,
    input  logic             load,
    input  logic             flag_en,
    input  logic             flag_rst,
    output logic             flag,
    output logic             overflow
);
    localparam int SUB_W = (SUB > 1) ? $clog2(SUB) : 1;

    logic             load_q;
    logic             load_rise;
    logic             run;
    logic [SUB_W-1:0] sub_cnt;
    logic             sub_last;   // prescaler on its final tick
    logic             step;       // counter advances this cycle
    logic [WIDTH-1:0] cnt;

    assign load_rise = load & ~load_q;
    assign run       = load & load_q;       // loaded and past the copy cycle
    assign sub_last  = (sub_cnt == SUB_W'(SUB - 1));
    assign step      = tick & run & sub_last;
    assign overflow  = step & (&cnt);       // passing all ones

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load;
        end
    end

    // prescaler restarts at each load so the first period is whole
    // stays at zero when SUB is 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sub_cnt <= '0;
        end else if (load_rise) begin
            sub_cnt <= '0;
        end else if (tick && run) begin
            sub_cnt <= sub_last ? '0 : sub_cnt + SUB_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (load_rise) begin
            cnt <= value;               // copy on 0->1 of load
        end else if (step) begin
            cnt <= overflow ? value : cnt + WIDTH'(1);
        end
        // load low just holds
    end

    // sticky flag; a fresh overflow beats a reset in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (overflow && flag_en) begin
            flag <= 1'b1;
        end else if (flag_rst) begin
            flag <= 1'b0;
        end
    end

    // wraps only on a tick and only once load has been held
    a_ovf_on_tick: assert property (@(posedge clk) disable iff (!arst_n)
        overflow |-> tick && $past(load));

endmodule

// ==== verilog/opn_reg_decode.sv ====
//------------------------------
// host register file and write busy logic
// feeds the divider setting and both timers
//------------------------------
`include "opn_cfg.svh"

module opn_reg_decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  opn_reg_pkg::host_wr_t    wr,
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  logic                     tick,
    output opn_timing_pkg::div_sel_e div_sel,
    output logic [`OPN_TA_W-1:0]     ta_value,
    output logic [`OPN_TB_W-1:0]     tb_value,
    output opn_reg_pkg::timer_ctl_t  ctl,
    output logic                     ctl_wr
);
    import opn_reg_pkg::*;
    import opn_timing_pkg::*;

    localparam int BUSY_W = $clog2(`OPN_BUSY_TICKS + 1);

    logic [BUSY_W-1:0] busy_cnt;   // opn strobes left before ready
    logic [7:0]        ta_hi;
    logic [1:0]        ta_lo;
    logic              xfer;

    assign xfer     = wr_valid & wr_ready;
    assign wr_ready = (busy_cnt == '0);
    assign ta_value = {ta_hi, ta_lo};   // lo only takes effect at next load

    // busy window
    // a strobe in the transfer cycle itself does not count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= '0;
        end else if (xfer) begin
            busy_cnt <= BUSY_W'(`OPN_BUSY_TICKS);
        end else if (tick && (busy_cnt != '0)) begin
            busy_cnt <= busy_cnt - BUSY_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ta_hi    <= '0;
            ta_lo    <= '0;
            tb_value <= '0;
            ctl      <= '0;
            ctl_wr   <= 1'b0;
            div_sel  <= DIV_6;      // power-on ratio
        end else begin
            ctl_wr <= 1'b0;
            if (xfer) begin
                case (wr.addr)
                    REG_TA_HI: begin
                        ta_hi <= wr.data;
                    end
                    REG_TA_LO: begin
                        ta_lo <= wr.data[1:0];
                    end
                    REG_TB: begin
                        tb_value <= wr.data;
                    end
                    REG_TIMER_CTL: begin
                        ctl    <= timer_ctl_t'(wr.data);
                        ctl_wr <= 1'b1;   // lines up with the new ctl
                    end
                    REG_PRESCALE: begin
                        div_sel <= div_sel_e'(wr.data[1:0]);
                    end
                    default: begin
                        // unmapped address, beat taken and dropped
                    end
                endcase
            end
        end
    end

    // host must not get a beat in during the busy window
    a_no_xfer_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (busy_cnt != '0) |-> !(wr_valid && wr_ready));

endmodule

// ==== verilog/opn_timing_top.sv ====
//------------------------------
// timing subsystem top with decoder, divider and timers
// host writes in, strobes and irq out
//------------------------------
`include "opn_cfg.svh"

module opn_timing_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cen,
    input  opn_reg_pkg::host_wr_t   wr,
    input  logic                    wr_valid,
    output logic                    wr_ready,
    output opn_timing_pkg::strobe_t stb,
    output logic                    irq,
    output logic [1:0]              status
);
    import opn_reg_pkg::*;
    import opn_timing_pkg::*;

    div_sel_e             div_sel;
    timer_ctl_t           ctl;
    logic                 ctl_wr;      // ctl just written
    logic [`OPN_TA_W-1:0] ta_value;
    logic [`OPN_TB_W-1:0] tb_value;
    logic                 flag_a;
    logic                 flag_b;

    opn_reg_decode u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (wr),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .tick     (stb.opn),
        .div_sel  (div_sel),
        .ta_value (ta_value),
        .tb_value (tb_value),
        .ctl      (ctl),
        .ctl_wr   (ctl_wr)
    );

    opn_clk_div u_div (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen     (cen),
        .div_sel (div_sel),
        .stb     (stb)
    );

    opn_timer #(
        .WIDTH (`OPN_TA_W),
        .SUB   (1)
    ) timer_a (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (stb.opn),
        .value    (ta_value),
        .load     (ctl.load_a),
        .flag_en  (ctl.flag_en_a),
        .flag_rst (ctl_wr & ctl.rst_a),
        .flag     (flag_a),
        .overflow ()
    );

    // timer b runs 16x slower
    opn_timer #(
        .WIDTH (`OPN_TB_W),
        .SUB   (`OPN_TB_SUB)
    ) timer_b (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (stb.opn),
        .value    (tb_value),
        .load     (ctl.load_b),
        .flag_en  (ctl.flag_en_b),
        .flag_rst (ctl_wr & ctl.rst_b),
        .flag     (flag_b),
        .overflow ()
    );

    assign status = {flag_b, flag_a};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= flag_a | flag_b;   // one cycle behind the flags
        end
    end

endmodule

// ==== verif/opn_timing_tb.sv ====
//------------------------------
// testbench for the OPN timing block
// cen counting model, assertions compare the DUT
//------------------------------
`include "opn_cfg.svh"

module opn_timing_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import opn_reg_pkg::*;
    import opn_timing_pkg::*;

    localparam bit SSG_ON  = (`OPN_USE_SSG != 0) && (`OPN_NUM_CH != 6);
    localparam int TA_FULL = 1 << `OPN_TA_W;
    localparam int TB_FULL = 1 << `OPN_TB_W;
    localparam int TA_IVL  = TA_FULL - 1000;               // timer a loaded with 1000
    localparam int TB_IVL  = (TB_FULL - 254) * `OPN_TB_SUB; // timer b loaded with 254
    // reset, then cycle estimates of tests 1 to 6
    localparam int RUN_LEN = 10 + 400 + 350 + 120 + 180 + 230 + 120;
    localparam int LIMIT   = RUN_LEN * 3 / 2;

    logic       clk;
    logic       arst_n;
    logic       cen;
    host_wr_t   wr;
    logic       wr_valid;
    logic       wr_ready;
    strobe_t    stb;
    logic       irq;
    logic [1:0] status;

    logic [7:0] lfsr;
    int         cen_mode;       // 0 low, 1 high, 2 lfsr
    int         errors;
    int         errors_before;
    int         tests;
    int         cycles;
    int         opn_total;      // opn strobes seen so far

    // reference model state
    logic [1:0] m_div;
    int         m_opn_ph;
    int         m_ssg_ph;
    int         m_quarter;      // opn wraps mod 4, adpcm phase
    strobe_t    m_stb;
    int         m_busy;
    logic       m_ready;
    logic       m_xfer;
    logic [9:0] m_ta;
    logic [7:0] m_tb;
    timer_ctl_t m_ctl;
    logic       m_ctl_wr;
    logic       m_load_a_q;
    logic       m_load_b_q;
    int         m_left_a;       // strobes to next overflow
    int         m_left_b;
    logic       m_ovf_a;
    logic       m_ovf_b;
    logic       m_flag_a;
    logic       m_flag_b;
    logic       m_irq;

    opn_timing_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .cen      (cen),
        .wr       (wr),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .stb      (stb),
        .irq      (irq),
        .status   (status)
    );

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);  // x^8+x^6+x^5+x^4+1
    endfunction

    function automatic int opn_period(input logic [1:0] sel);
        if (`OPN_NUM_CH == 6) return 6;
        case (sel)
            2'b10:   return 6;
            2'b11:   return 3;
            default: return 2;
        endcase
    endfunction

    function automatic int ssg_period(input logic [1:0] sel);
        if (`OPN_NUM_CH == 6) return 4;
        case (sel)
            2'b10:   return 4;
            2'b11:   return 2;
            default: return 1;
        endcase
    endfunction

    assign m_ready = (m_busy == 0);
    assign m_xfer  = wr_valid && m_ready;
    assign m_ovf_a = m_stb.opn && m_ctl.load_a && m_load_a_q && (m_left_a == 1);
    assign m_ovf_b = m_stb.opn && m_ctl.load_b && m_load_b_q && (m_left_b == 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_div      <= 2'b10;    // /6 out of reset
            m_opn_ph   <= 0;
            m_ssg_ph   <= 0;
            m_quarter  <= 0;
            m_stb      <= '0;
            m_busy     <= 0;
            m_ta       <= '0;
            m_tb       <= '0;
            m_ctl      <= '0;
            m_ctl_wr   <= 1'b0;
            m_load_a_q <= 1'b0;
            m_load_b_q <= 1'b0;
            m_left_a   <= 0;
            m_left_b   <= 0;
            m_flag_a   <= 1'b0;
            m_flag_b   <= 1'b0;
            m_irq      <= 1'b0;
        end else begin
            // counters wrap at period minus one, at once if past a new shorter period
            if (cen) begin
                m_opn_ph <= (m_opn_ph >= opn_period(m_div) - 1) ? 0 : m_opn_ph + 1;
                m_ssg_ph <= (m_ssg_ph >= ssg_period(m_div) - 1) ? 0 : m_ssg_ph + 1;
                if (m_opn_ph == 0) m_quarter <= (m_quarter + 1) % 4;
            end
            m_stb.opn   <= cen && (m_opn_ph == 0);
            m_stb.ssg   <= SSG_ON && cen && (m_ssg_ph == 0);
            m_stb.adpcm <= cen && (m_opn_ph == 0) && (m_quarter == 0);
            // busy counts opn strobes after the transfer cycle
            if (m_xfer) m_busy <= `OPN_BUSY_TICKS;
            else if (m_stb.opn && m_busy > 0) m_busy <= m_busy - 1;
            if (m_xfer) begin
                case (wr.addr)
                    REG_TA_HI:     m_ta[9:2] <= wr.data;
                    REG_TA_LO:     m_ta[1:0] <= wr.data[1:0];
                    REG_TB:        m_tb <= wr.data;
                    REG_TIMER_CTL: m_ctl <= timer_ctl_t'(wr.data);
                    REG_PRESCALE:  m_div <= wr.data[1:0];
                    default: begin
                    end
                endcase
            end
            m_ctl_wr   <= m_xfer && (wr.addr == REG_TIMER_CTL);
            m_load_a_q <= m_ctl.load_a;
            m_load_b_q <= m_ctl.load_b;
            // intervals straight from the overflow formulas
            if ((m_ctl.load_a && !m_load_a_q) || m_ovf_a) m_left_a <= TA_FULL - int'(m_ta);
            else if (m_stb.opn && m_ctl.load_a && m_load_a_q) m_left_a <= m_left_a - 1;
            if ((m_ctl.load_b && !m_load_b_q) || m_ovf_b) begin
                m_left_b <= (TB_FULL - int'(m_tb)) * `OPN_TB_SUB;
            end else if (m_stb.opn && m_ctl.load_b && m_load_b_q) begin
                m_left_b <= m_left_b - 1;
            end
            if (m_ovf_a && m_ctl.flag_en_a) m_flag_a <= 1'b1;
            else if (m_ctl_wr && m_ctl.rst_a) m_flag_a <= 1'b0;
            if (m_ovf_b && m_ctl.flag_en_b) m_flag_b <= 1'b1;
            else if (m_ctl_wr && m_ctl.rst_b) m_flag_b <= 1'b0;
            m_irq <= m_flag_a || m_flag_b;
        end
    end

    a_strobes: assert property (@(posedge clk) disable iff (!arst_n) stb == m_stb)
        else report_mismatch("stb", {29'b0, stb}, {29'b0, m_stb});
    a_ready: assert property (@(posedge clk) disable iff (!arst_n) wr_ready == m_ready)
        else report_mismatch("wr_ready", {31'b0, wr_ready}, {31'b0, m_ready});
    a_status: assert property (@(posedge clk) disable iff (!arst_n)
        status == {m_flag_b, m_flag_a})
        else report_mismatch("status", {30'b0, status}, {30'b0, m_flag_b, m_flag_a});
    a_irq: assert property (@(posedge clk) disable iff (!arst_n) irq == m_irq)
        else report_mismatch("irq", {31'b0, irq}, {31'b0, m_irq});
    a_opn_after_cen: assert property (@(posedge clk) disable iff (!arst_n)
        stb.opn |-> $past(cen))
        else begin
            errors++;
            $display("ERROR %0t: opn strobe without a cen in the cycle before", $time);
        end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    // called and returns 1 ns after a rising edge
    task automatic host_write(input reg_addr_e addr, input logic [7:0] data);
        wr.addr  = addr;
        wr.data  = data;
        wr_valid = 1'b1;
        while (!wr_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);     // transfer edge
        #1;
        wr_valid = 1'b0;
    endtask

    task automatic run_opn(input int n);
        int target;
        target = opn_total + n;
        while (opn_total < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_flag(input logic [1:0] mask);
        while ((status & mask) == 2'b00) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic select_divider(input logic [1:0] sel, input int n);
        host_write(REG_PRESCALE, {6'b0, sel});
        run_opn(n);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cen source, one lfsr bit per cycle in random mode
    initial begin
        cen  = 1'b0;
        lfsr = 8'd61;
        forever begin
            @(posedge clk);
            #1;
            if (cen_mode == 2) begin
                cen  = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end else begin
                cen = (cen_mode == 1);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (stb.opn) opn_total++;
        if (cycles > LIMIT) begin
            $display("timeout: run still going after %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int base;
        int n;
        arst_n        = 1'b0;
        wr            = '0;
        wr_valid      = 1'b0;
        cen_mode      = 0;
        errors        = 0;
        errors_before = 0;
        tests         = 0;
        cycles        = 0;
        opn_total     = 0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        cen_mode = 1;               // every ratio, cen held high
        select_divider(2'b10, 16);
        select_divider(2'b11, 16);
        select_divider(2'b01, 16);
        select_divider(2'b00, 16);
        end_test("strobe periods");

        cen_mode = 2;
        select_divider(2'b11, 40);
        end_test("gated cen");

        host_write(REG_PRESCALE, 8'h00);        // back to back, still random cen
        host_write(reg_addr_e'(8'h30), 8'h55);  // unmapped, dropped
        host_write(REG_TB, 8'hFE);
        host_write(REG_TA_LO, 8'h00);
        end_test("busy");

        cen_mode = 1;
        host_write(REG_TA_HI, 8'hFA);           // 1000 with lo bits 0
        host_write(REG_TIMER_CTL, 8'h05);       // load_a, flag_en_a
        base = opn_total + (stb.opn ? 1 : 0);   // copy cycle strobe not counted
        wait_flag(2'b01);
        n = opn_total - base;
        assert (n == TA_IVL) else report_mismatch("timer a first interval", n, TA_IVL);
        base = opn_total;                       // next interval starts after overflow
        host_write(REG_TIMER_CTL, 8'h15);       // rst_a, load held so no copy
        @(posedge clk);
        #1;
        wait_flag(2'b01);
        n = opn_total - base;
        assert (n == TA_IVL) else report_mismatch("timer a second interval", n, TA_IVL);
        end_test("timer a");

        host_write(REG_TIMER_CTL, 8'h0A);       // load_b, flag_en_b, timer a frozen
        base = opn_total + (stb.opn ? 1 : 0);
        wait_flag(2'b10);
        n = opn_total - base;
        assert (n == TB_IVL) else report_mismatch("timer b interval", n, TB_IVL);
        host_write(REG_TIMER_CTL, 8'h22);       // rst_b, flag_en_b off, still running
        run_opn(2 * TB_IVL);
        assert (!status[1])
            else report_mismatch("timer b flag with flag_en clear", {31'b0, status[1]}, 0);
        end_test("timer b");

        host_write(REG_TIMER_CTL, 8'h36);       // both rst, flag_en_a, load_a low
        @(posedge clk);
        #1;
        assert (status == 2'b00 && irq)
            else report_mismatch("status and irq after reset", {29'b0, irq, status}, 4);
        @(posedge clk);
        #1;
        assert (!irq) else report_mismatch("irq one cycle later", {31'b0, irq}, 0);
        run_opn(2 * TA_IVL);                    // frozen timer a never wraps
        assert (status == 2'b00)
            else report_mismatch("status with timer a stopped", {30'b0, status}, 0);
        end_test("flag reset and stop");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/opn_reg_pkg.sv
common/opn_timing_pkg.sv
verilog/opn_clk_div.sv
timers/opn_timer.sv
verilog/opn_reg_decode.sv
verilog/opn_timing_top.sv
verif/opn_timing_tb.sv

// ==== Makefile ====
# Verilator build and run of the OPN timing testbench

TOP = opn_timing_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f filelist.f

# pass only if the run prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
